/* backlight_fader.sv */
`timescale 1ns/1ps
`default_nettype none

module backlight_fader (
	input  logic tft_new_frame,
	input  logic rst_n,
	input  logic pressed,
	input  logic [touch_frame_pkg::DUTY_W-1:0] duty_target,
	output logic [touch_frame_pkg::DUTY_W-1:0] backlight_duty
);

	logic [touch_frame_pkg::DUTY_W-1:0] target;
	logic [touch_frame_pkg::DUTY_W-1:0] distance;
	logic [touch_frame_pkg::DUTY_W-1:0] next_duty;
	logic going_up;

	// full brightness overrides the switches while held
	assign target = pressed ? touch_frame_pkg::DUTY_FULL : duty_target;

	assign going_up = (target > backlight_duty);

	always_comb begin
		if (going_up) begin
			distance = target - backlight_duty;
		end else begin
			distance = backlight_duty - target;
		end
	end

	// close enough, snap; otherwise one step toward the target
	always_comb begin
		if (distance <= touch_frame_pkg::FADE_STEP) begin
			next_duty = target;
		end else if (going_up) begin
			next_duty = backlight_duty + touch_frame_pkg::FADE_STEP;
		end else begin
			next_duty = backlight_duty - touch_frame_pkg::FADE_STEP;
		end
	end

	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			backlight_duty <= '0;
		end else begin
			backlight_duty <= next_duty;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the touch frame testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_touch_frame_top
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
	--top-module "$TOP" \
	-f touch_frame_top.f \
	-o "$TOP" \
	|| { echo "build failed"; exit 1; }

./obj_dir/"$TOP" > "$LOG" 2>&1 || echo "simulator exited with an error"
cat "$LOG"

grep -qxF "** PASS **" "$LOG" && echo "result: passed" && exit 0 \
	|| { echo "result: failed"; exit 1; }

/* tb_touch_frame_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_touch_frame_top;

	logic tft_new_frame;
	logic rst_n;
	logic [touch_frame_pkg::COORD_W-1:0] touch_x;
	logic [touch_frame_pkg::COORD_W-1:0] touch_y;
	logic [touch_frame_pkg::COORD_W-1:0] touch_z;
	logic [touch_frame_pkg::DUTY_W-1:0] duty_target;
	logic pressed;
	logic press_pulse;
	logic release_pulse;
	logic [touch_frame_pkg::COORD_W-1:0] locked_x;
	logic [touch_frame_pkg::COORD_W-1:0] locked_y;
	logic [touch_frame_pkg::DUTY_W-1:0] backlight_duty;

	// reference model, one variable per pipeline register
	logic [touch_frame_pkg::COORD_W-1:0] m_cal_x;
	logic [touch_frame_pkg::COORD_W-1:0] m_cal_y;
	logic m_contact;
	touch_frame_pkg::touch_state_t m_state;
	int m_cnt;
	logic m_press_pulse;
	logic m_release_pulse;
	logic [touch_frame_pkg::COORD_W-1:0] m_locked_x;
	logic [touch_frame_pkg::COORD_W-1:0] m_locked_y;
	logic [touch_frame_pkg::DUTY_W-1:0] m_duty;

	int mismatch_count;
	int timeout_count;
	int frame_count;
	int press_count;
	int release_count;
	int last_duty;
	bit reset_seen;
	bit vary_duty;

	touch_frame_top uut (
		.tft_new_frame  (tft_new_frame),
		.rst_n          (rst_n),
		.touch_x        (touch_x),
		.touch_y        (touch_y),
		.touch_z        (touch_z),
		.duty_target    (duty_target),
		.pressed        (pressed),
		.press_pulse    (press_pulse),
		.release_pulse  (release_pulse),
		.locked_x       (locked_x),
		.locked_y       (locked_y),
		.backlight_duty (backlight_duty)
	);

	bind touch_tracker touch_frame_properties u_properties (
		.tft_new_frame (tft_new_frame),
		.rst_n         (rst_n),
		.pressed       (pressed),
		.press_pulse   (press_pulse),
		.release_pulse (release_pulse)
	);

	initial begin
		tft_new_frame = 1'b0;
		forever begin
			#4 tft_new_frame = ~tft_new_frame;
		end
	end

	// offset removed with a floor at zero, then scaled down
	function automatic logic [touch_frame_pkg::COORD_W-1:0] expected_coord(
		input int raw,
		input int offset
	);
		int diff;
		diff = raw - offset;
		if (diff < 0) begin
			diff = 0;
		end
		return touch_frame_pkg::COORD_W'(diff >> touch_frame_pkg::COORD_SHIFT);
	endfunction

	task automatic update_model();
		logic [touch_frame_pkg::COORD_W-1:0] n_cal_x;
		logic [touch_frame_pkg::COORD_W-1:0] n_cal_y;
		logic n_contact;
		touch_frame_pkg::touch_state_t n_state;
		int n_cnt;
		logic n_press;
		logic n_release;
		bit was_pressed;
		int target;
		int cur;
		int step;
		if (!rst_n) begin
			m_cal_x = '0;
			m_cal_y = '0;
			m_contact = 1'b0;
			m_state = touch_frame_pkg::TOUCH_IDLE;
			m_cnt = 0;
			m_press_pulse = 1'b0;
			m_release_pulse = 1'b0;
			m_locked_x = '0;
			m_locked_y = '0;
			m_duty = '0;
			reset_seen = 1'b1;
		end else begin
			n_cal_x = expected_coord(int'(touch_x), int'(touch_frame_pkg::X_OFFSET));
			n_cal_y = expected_coord(int'(touch_y), int'(touch_frame_pkg::Y_OFFSET));
			n_contact = (int'(touch_z) >= (1 << touch_frame_pkg::Z_SHIFT));
			was_pressed = (m_state == touch_frame_pkg::TOUCH_HELD) ||
				(m_state == touch_frame_pkg::TOUCH_LEAVING);
			n_state = m_state;
			n_cnt = m_cnt;
			n_press = 1'b0;
			n_release = 1'b0;
			case (m_state)
				touch_frame_pkg::TOUCH_IDLE: begin
					if (m_contact) begin
						n_state = touch_frame_pkg::TOUCH_ARMING;
						n_cnt = 1;
					end
				end
				touch_frame_pkg::TOUCH_ARMING: begin
					if (!m_contact) begin
						n_state = touch_frame_pkg::TOUCH_IDLE;
					end else if (m_cnt == int'(touch_frame_pkg::PRESS_FRAMES) - 1) begin
						n_state = touch_frame_pkg::TOUCH_HELD;
						n_press = 1'b1;
					end else begin
						n_cnt = m_cnt + 1;
					end
				end
				touch_frame_pkg::TOUCH_HELD: begin
					if (!m_contact) begin
						n_state = touch_frame_pkg::TOUCH_LEAVING;
						n_cnt = 1;
					end
				end
				default: begin
					if (m_contact) begin
						n_state = touch_frame_pkg::TOUCH_HELD;
					end else if (m_cnt == int'(touch_frame_pkg::RELEASE_FRAMES) - 1) begin
						n_state = touch_frame_pkg::TOUCH_IDLE;
						n_release = 1'b1;
					end else begin
						n_cnt = m_cnt + 1;
					end
				end
			endcase
			if (n_state == touch_frame_pkg::TOUCH_HELD) begin
				m_locked_x = m_cal_x;
				m_locked_y = m_cal_y;
			end
			// fader sees pressed from before this edge
			target = was_pressed ? int'(touch_frame_pkg::DUTY_FULL) : int'(duty_target);
			cur = int'(m_duty);
			step = int'(touch_frame_pkg::FADE_STEP);
			if (target > cur + step) begin
				cur = cur + step;
			end else if (target < cur - step) begin
				cur = cur - step;
			end else begin
				cur = target;
			end
			m_duty = touch_frame_pkg::DUTY_W'(cur);
			m_state = n_state;
			m_cnt = n_cnt;
			m_press_pulse = n_press;
			m_release_pulse = n_release;
			m_cal_x = n_cal_x;
			m_cal_y = n_cal_y;
			m_contact = n_contact;
		end
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, expected);
			mismatch_count = mismatch_count + 1;
		end
	endtask

	task automatic compare_outputs();
		int duty_step;
		check_value("pressed", int'(pressed), int'((m_state == touch_frame_pkg::TOUCH_HELD) ||
			(m_state == touch_frame_pkg::TOUCH_LEAVING)));
		check_value("press_pulse", int'(press_pulse), int'(m_press_pulse));
		check_value("release_pulse", int'(release_pulse), int'(m_release_pulse));
		check_value("locked_x", int'(locked_x), int'(m_locked_x));
		check_value("locked_y", int'(locked_y), int'(m_locked_y));
		check_value("backlight_duty", int'(backlight_duty), int'(m_duty));
		duty_step = int'(backlight_duty) - last_duty;
		if (duty_step > int'(touch_frame_pkg::FADE_STEP) ||
			duty_step < -int'(touch_frame_pkg::FADE_STEP)) begin
			$display("MISMATCH at %0t: backlight_duty moved by %0d in one frame", $time, duty_step);
			mismatch_count = mismatch_count + 1;
		end
		last_duty = int'(backlight_duty);
	endtask

	// model runs on the edge, DUT outputs are compared once settled
	always @(posedge tft_new_frame) begin
		update_model();
		#1;
		if (reset_seen) begin
			compare_outputs();
			frame_count = frame_count + 1;
			if (press_pulse) begin
				press_count = press_count + 1;
			end
			if (release_pulse) begin
				release_count = release_count + 1;
			end
		end
	end

	task automatic drive_frame(input bit touching);
		@(negedge tft_new_frame);
		touch_x = touch_frame_pkg::COORD_W'($urandom);
		touch_y = touch_frame_pkg::COORD_W'($urandom);
		if (touching) begin
			touch_z = touch_frame_pkg::COORD_W'($urandom_range(256, 4095));
		end else begin
			touch_z = touch_frame_pkg::COORD_W'($urandom_range(0, 255));
		end
		if (vary_duty && $urandom_range(0, 9) == 0) begin
			duty_target = touch_frame_pkg::DUTY_W'($urandom);
		end
	endtask

	task automatic drive_fixed(input int x, input int y, input int z);
		@(negedge tft_new_frame);
		touch_x = touch_frame_pkg::COORD_W'(x);
		touch_y = touch_frame_pkg::COORD_W'(y);
		touch_z = touch_frame_pkg::COORD_W'(z);
	endtask

	// edges counts the first edge after the inputs changed as 1
	task automatic wait_for_pulse(input bit release_evt, input int limit, output int edges);
		bit seen;
		seen = 1'b0;
		edges = 0;
		while (!seen && edges < limit) begin
			@(posedge tft_new_frame);
			#1;
			edges = edges + 1;
			seen = release_evt ? release_pulse : press_pulse;
		end
		if (!seen) begin
			$display("timeout: no %s pulse within %0d frames",
				release_evt ? "release" : "press", limit);
			timeout_count = timeout_count + 1;
		end
	endtask

	task automatic wait_duty_settle(input int limit);
		int frames;
		frames = 0;
		while (backlight_duty != duty_target && frames < limit) begin
			@(posedge tft_new_frame);
			#1;
			frames = frames + 1;
		end
		if (backlight_duty != duty_target) begin
			$display("timeout: backlight duty did not settle on %0d within %0d frames",
				duty_target, limit);
			timeout_count = timeout_count + 1;
		end
	endtask

	task automatic report_error(input string what);
		$display("MISMATCH at %0t: %s", $time, what);
		mismatch_count = mismatch_count + 1;
	endtask

	initial begin
		int edges;
		int run_len;
		int burst;
		int presses_before;
		int releases_before;
		void'($urandom(30));
		mismatch_count = 0;
		timeout_count = 0;
		frame_count = 0;
		press_count = 0;
		release_count = 0;
		last_duty = 0;
		reset_seen = 1'b0;
		vary_duty = 1'b0;
		rst_n = 1'b0;
		touch_x = '0;
		touch_y = '0;
		touch_z = '0;
		duty_target = '0;
		repeat (10) @(posedge tft_new_frame);
		@(negedge tft_new_frame);
		rst_n = 1'b1;

		// light pressure only, nothing may move
		repeat (12) drive_frame(1'b0);
		@(posedge tft_new_frame);
		#2;
		if (pressed || press_pulse || release_pulse || locked_x != '0 || locked_y != '0 ||
			backlight_duty != '0) begin
			report_error("outputs not all zero while pressure stays low");
		end

		// runs of 1 and 2 frames are glitches
		presses_before = press_count;
		drive_frame(1'b1);
		repeat (3) drive_frame(1'b0);
		repeat (2) drive_frame(1'b1);
		repeat (3) drive_frame(1'b0);
		@(posedge tft_new_frame);
		#2;
		if (press_count != presses_before || locked_x != '0 || locked_y != '0) begin
			report_error("short contact run raised press_pulse or moved the coordinates");
		end

		drive_fixed(1000, 1500, 3000);
		wait_for_pulse(1'b0, 20, edges);
		if (edges != int'(touch_frame_pkg::PRESS_FRAMES) + 1) begin
			report_error($sformatf("press_pulse after %0d edges, expected %0d",
				edges, touch_frame_pkg::PRESS_FRAMES + 1));
		end

		// raw readings below the offsets
		repeat (3) drive_fixed(100, 200, 3000);
		@(posedge tft_new_frame);
		#1;
		if (locked_x != '0 || locked_y != '0) begin
			report_error($sformatf("locked %0d,%0d below offsets, expected 0,0",
				locked_x, locked_y));
		end

		// one lost frame is bridged
		releases_before = release_count;
		drive_fixed(2000, 2000, 0);
		repeat (3) drive_fixed(2000, 2000, 3000);
		@(posedge tft_new_frame);
		#2;
		if (release_count != releases_before || !pressed) begin
			report_error("single no-contact frame released the panel");
		end

		drive_fixed(2000, 2000, 0);
		wait_for_pulse(1'b1, 20, edges);
		if (edges != int'(touch_frame_pkg::RELEASE_FRAMES) + 1) begin
			report_error($sformatf("release_pulse after %0d edges, expected %0d",
				edges, touch_frame_pkg::RELEASE_FRAMES + 1));
		end
		if (pressed) begin
			report_error("pressed still high with release_pulse");
		end

		@(negedge tft_new_frame);
		duty_target = touch_frame_pkg::DUTY_W'(200);
		wait_duty_settle(100);

		// random bursts of contact and no contact
		vary_duty = 1'b1;
		for (burst = 0; burst < 80; burst = burst + 1) begin
			run_len = $urandom_range(1, 6);
			repeat (run_len) drive_frame(1'b1);
			run_len = $urandom_range(1, 6);
			repeat (run_len) drive_frame(1'b0);
		end

		vary_duty = 1'b0;
		repeat (3) drive_frame(1'b0);
		@(negedge tft_new_frame);
		duty_target = touch_frame_pkg::DUTY_W'($urandom_range(0, 255));
		wait_duty_settle(120);

		$display("frames checked %0d, presses %0d, releases %0d, mismatches %0d, timeouts %0d",
			frame_count, press_count, release_count, mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* touch_calibrate.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_calibrate (
	input  logic tft_new_frame,
	input  logic rst_n,
	input  logic [touch_frame_pkg::COORD_W-1:0] touch_x,
	input  logic [touch_frame_pkg::COORD_W-1:0] touch_y,
	input  logic [touch_frame_pkg::COORD_W-1:0] touch_z,
	output logic [touch_frame_pkg::COORD_W-1:0] cal_x,
	output logic [touch_frame_pkg::COORD_W-1:0] cal_y,
	output logic contact
);

	// subtract the edge offset, floor at zero, then scale to pixels
	function automatic logic [touch_frame_pkg::COORD_W-1:0] clamp_scale(
		input logic [touch_frame_pkg::COORD_W-1:0] raw,
		input logic [touch_frame_pkg::COORD_W-1:0] offset
	);
		logic [touch_frame_pkg::COORD_W-1:0] diff;
		if (raw < offset) begin
			diff = '0;
		end else begin
			diff = raw - offset;
		end
		return diff >> touch_frame_pkg::COORD_SHIFT;
	endfunction

	logic [touch_frame_pkg::COORD_W-1:0] x_scaled;
	logic [touch_frame_pkg::COORD_W-1:0] y_scaled;
	logic z_over;

	always_comb begin
		x_scaled = clamp_scale(touch_x, touch_frame_pkg::X_OFFSET);
		y_scaled = clamp_scale(touch_y, touch_frame_pkg::Y_OFFSET);
	end

	// only the high bits of pressure matter
	assign z_over = ((touch_z >> touch_frame_pkg::Z_SHIFT) != '0);

	// one register stage per frame
	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			cal_x   <= '0;
			cal_y   <= '0;
			contact <= 1'b0;
		end else begin
			cal_x   <= x_scaled;
			cal_y   <= y_scaled;
			contact <= z_over;
		end
	end

endmodule

`default_nettype wire

/* touch_frame_pkg.sv */
`default_nettype none

package touch_frame_pkg;

	// coordinate and pressure width from the touch controller
	localparam int unsigned COORD_W = 12;

	// raw readings at the panel's left and top edges
	localparam logic [COORD_W-1:0] X_OFFSET = COORD_W'(150);
	localparam logic [COORD_W-1:0] Y_OFFSET = COORD_W'(300);

	// raw to pixel scale
	localparam int unsigned COORD_SHIFT = 2;

	// pressure of 256 or more means a finger is down
	localparam int unsigned Z_SHIFT = 8;

	// debounce lengths, in frames
	localparam int unsigned PRESS_FRAMES = 3;
	localparam int unsigned RELEASE_FRAMES = 2;
	localparam int unsigned CNT_W = 2;

	// backlight duty
	localparam int unsigned DUTY_W = 8;
	localparam logic [DUTY_W-1:0] DUTY_FULL = DUTY_W'(255);
	localparam logic [DUTY_W-1:0] FADE_STEP = DUTY_W'(4);

	typedef enum logic [1:0] {
		TOUCH_IDLE    = 2'd0,
		TOUCH_ARMING  = 2'd1,
		TOUCH_HELD    = 2'd2,
		TOUCH_LEAVING = 2'd3
	} touch_state_t;

endpackage

`default_nettype wire

/* touch_frame_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_frame_properties (
	input logic tft_new_frame,
	input logic rst_n,
	input logic pressed,
	input logic press_pulse,
	input logic release_pulse
);

	// press and release are separate events
	property pulses_exclusive;
		@(posedge tft_new_frame) disable iff (!rst_n)
		!(press_pulse && release_pulse);
	endproperty

	property press_one_cycle;
		@(posedge tft_new_frame) disable iff (!rst_n)
		press_pulse |=> !press_pulse;
	endproperty

	property release_one_cycle;
		@(posedge tft_new_frame) disable iff (!rst_n)
		release_pulse |=> !release_pulse;
	endproperty

	// entering HELD is the only way into the pressed states
	property pressed_rises_with_press;
		@(posedge tft_new_frame) disable iff (!rst_n)
		$rose(pressed) |-> press_pulse;
	endproperty

	assert property (pulses_exclusive)
		else $error("press_pulse and release_pulse high together");
	assert property (press_one_cycle)
		else $error("press_pulse longer than one frame");
	assert property (release_one_cycle)
		else $error("release_pulse longer than one frame");
	assert property (pressed_rises_with_press)
		else $error("pressed rose without press_pulse");

endmodule

`default_nettype wire

/* touch_frame_top.f */
touch_frame_pkg.sv
touch_calibrate.sv
touch_tracker.sv
backlight_fader.sv
touch_frame_top.sv
touch_frame_properties.sv
tb_touch_frame_top.sv

/* touch_frame_top.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_frame_top (
	input  logic tft_new_frame,
	input  logic rst_n,
	input  logic [touch_frame_pkg::COORD_W-1:0] touch_x,
	input  logic [touch_frame_pkg::COORD_W-1:0] touch_y,
	input  logic [touch_frame_pkg::COORD_W-1:0] touch_z,
	input  logic [touch_frame_pkg::DUTY_W-1:0] duty_target,
	output logic pressed,
	output logic press_pulse,
	output logic release_pulse,
	output logic [touch_frame_pkg::COORD_W-1:0] locked_x,
	output logic [touch_frame_pkg::COORD_W-1:0] locked_y,
	output logic [touch_frame_pkg::DUTY_W-1:0] backlight_duty
);

	// calibrated stage outputs
	logic [touch_frame_pkg::COORD_W-1:0] cal_x;
	logic [touch_frame_pkg::COORD_W-1:0] cal_y;
	logic contact;

	touch_calibrate u_calibrate (
		.tft_new_frame (tft_new_frame),
		.rst_n         (rst_n),
		.touch_x       (touch_x),
		.touch_y       (touch_y),
		.touch_z       (touch_z),
		.cal_x         (cal_x),
		.cal_y         (cal_y),
		.contact       (contact)
	);

	touch_tracker u_tracker (
		.tft_new_frame (tft_new_frame),
		.rst_n         (rst_n),
		.contact       (contact),
		.cal_x         (cal_x),
		.cal_y         (cal_y),
		.pressed       (pressed),
		.press_pulse   (press_pulse),
		.release_pulse (release_pulse),
		.locked_x      (locked_x),
		.locked_y      (locked_y)
	);

	// the fader sees pressed straight from the tracker
	backlight_fader u_fader (
		.tft_new_frame  (tft_new_frame),
		.rst_n          (rst_n),
		.pressed        (pressed),
		.duty_target    (duty_target),
		.backlight_duty (backlight_duty)
	);

endmodule

`default_nettype wire

/* touch_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_tracker (
	input  logic tft_new_frame,
	input  logic rst_n,
	input  logic contact,
	input  logic [touch_frame_pkg::COORD_W-1:0] cal_x,
	input  logic [touch_frame_pkg::COORD_W-1:0] cal_y,
	output logic pressed,
	output logic press_pulse,
	output logic release_pulse,
	output logic [touch_frame_pkg::COORD_W-1:0] locked_x,
	output logic [touch_frame_pkg::COORD_W-1:0] locked_y
);

	localparam logic [touch_frame_pkg::CNT_W-1:0] PRESS_LAST =
		touch_frame_pkg::CNT_W'(touch_frame_pkg::PRESS_FRAMES - 1);
	localparam logic [touch_frame_pkg::CNT_W-1:0] RELEASE_LAST =
		touch_frame_pkg::CNT_W'(touch_frame_pkg::RELEASE_FRAMES - 1);
	localparam logic [touch_frame_pkg::CNT_W-1:0] CNT_ONE =
		touch_frame_pkg::CNT_W'(1);

	touch_frame_pkg::touch_state_t state;
	touch_frame_pkg::touch_state_t next_state;

	logic [touch_frame_pkg::CNT_W-1:0] cnt;
	logic [touch_frame_pkg::CNT_W-1:0] next_cnt;
	logic next_press;
	logic next_release;

	// next state, counter and event decode
	always_comb begin
		next_state   = state;
		next_cnt     = cnt;
		next_press   = 1'b0;
		next_release = 1'b0;

		case (state)
			touch_frame_pkg::TOUCH_IDLE: begin
				if (contact) begin
					next_state = touch_frame_pkg::TOUCH_ARMING;
					next_cnt   = CNT_ONE;
				end else begin
					next_cnt = '0;
				end
			end

			touch_frame_pkg::TOUCH_ARMING: begin
				if (!contact) begin
					// glitch, never confirmed
					next_state = touch_frame_pkg::TOUCH_IDLE;
					next_cnt   = '0;
				end else if (cnt == PRESS_LAST) begin
					next_state = touch_frame_pkg::TOUCH_HELD;
					next_cnt   = '0;
					next_press = 1'b1;
				end else begin
					next_cnt = cnt + CNT_ONE;
				end
			end

			touch_frame_pkg::TOUCH_HELD: begin
				if (!contact) begin
					next_state = touch_frame_pkg::TOUCH_LEAVING;
					next_cnt   = CNT_ONE;
				end
			end

			touch_frame_pkg::TOUCH_LEAVING: begin
				if (contact) begin
					// contact came back before release was confirmed
					next_state = touch_frame_pkg::TOUCH_HELD;
					next_cnt   = '0;
				end else if (cnt == RELEASE_LAST) begin
					next_state   = touch_frame_pkg::TOUCH_IDLE;
					next_cnt     = '0;
					next_release = 1'b1;
				end else begin
					next_cnt = cnt + CNT_ONE;
				end
			end

			default: begin
				next_state = touch_frame_pkg::TOUCH_IDLE;
				next_cnt   = '0;
			end
		endcase
	end

	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			state         <= touch_frame_pkg::TOUCH_IDLE;
			cnt           <= '0;
			press_pulse   <= 1'b0;
			release_pulse <= 1'b0;
		end else begin
			state         <= next_state;
			cnt           <= next_cnt;
			press_pulse   <= next_press;
			release_pulse <= next_release;
		end
	end

	// coordinates follow every frame that lands in HELD
	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			locked_x <= '0;
			locked_y <= '0;
		end else if (next_state == touch_frame_pkg::TOUCH_HELD) begin
			locked_x <= cal_x;
			locked_y <= cal_y;
		end
	end

	// still pressed while leaving, release is not confirmed yet
	assign pressed = (state == touch_frame_pkg::TOUCH_HELD) ||
		(state == touch_frame_pkg::TOUCH_LEAVING);

endmodule

`default_nettype wire
